// ==== src.f ====
+incdir+tb
verilog/wb_pkg.sv
verilog/retire_if.sv
verilog/exc_if.sv
verilog/writeback.sv
verilog/retire_lane.sv
verilog/regfile.sv
verilog/exception_csr.sv
verilog/wb_subsystem.sv
tb/tb_wb_subsystem.sv

// ==== tb/wb_vectors.svh ====
// lane pairs are written {lane 1, lane 0}
typedef struct {
    string            name;
    logic [1:0]       valid;
    logic [1:0][4:0]  rd;         // regs at these addresses are read back
    logic [1:0][31:0] data;
    logic [1:0][31:0] pc;
    logic [1:0][31:0] inst;
    logic [1:0][6:0]  exc;
    logic [1:0][31:0] badv;
    logic [1:0]       exp_wen;    // trace_wen per lane
    logic [31:0]      exp_r0;     // reg at rd of lane 0
    logic [31:0]      exp_r1;     // reg at rd of lane 1
    logic             exp_take;
    logic [31:0]      exp_redirect;
    logic [31:0]      exp_era;
    logic [31:0]      exp_estat;
    logic [31:0]      exp_badv;
    logic [31:0]      exp_tlbehi;
    logic [31:0]      exp_pgd;
    logic [31:0]      exp_crmd;
} vector_t;

localparam int NUM_ROWS = 6;

// ------------------------------
// stimulus, then expected values
// ------------------------------
vector_t vectors [NUM_ROWS] = '{
    '{"both_commit", 2'b11, {5'd2, 5'd1}, {32'h2222_0002, 32'h1111_0001},
      {32'h1c00_0004, 32'h1c00_0000}, {32'h0280_0802, 32'h0280_0401},
      {EXP_NONE, EXP_NONE}, 64'h0, 2'b11, 32'h1111_0001, 32'h2222_0002,
      1'b0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
    '{"lane0_ale", 2'b11, {5'd4, 5'd3}, {32'h4444_0004, 32'h3333_0003},
      {32'h1c00_0014, 32'h1c00_0010}, {32'h2880_0004, 32'h2880_0003},
      {EXP_NONE, EXP_ALE}, {32'h0, 32'h1c00_1003}, 2'b00, 32'h0, 32'h0,
      1'b1, 32'h1c00_8000, 32'h1c00_0010, 32'h0009_0000, 32'h1c00_1003,
      32'h0000_0000, 32'h0010_0000, 32'h0000_0010},
    '{"lane1_tlbr", 2'b11, {5'd6, 5'd5}, {32'h6666_0006, 32'h5555_0005},
      {32'h1c00_0024, 32'h1c00_0020}, {32'h2880_0006, 32'h0280_0505},
      {EXP_TLBR, EXP_NONE}, {32'h8765_4321, 32'h0}, 2'b01, 32'h5555_0005, 32'h0,
      1'b1, 32'h1c00_f000, 32'h1c00_0024, 32'h003f_0000, 32'h8765_4321,
      32'h8765_4000, 32'h0020_0000, 32'h0000_0008},
    '{"lane0_adem", 2'b11, {5'd8, 5'd7}, {32'h8888_0008, 32'h7777_0007},
      {32'h1c00_0034, 32'h1c00_0030}, {32'h0280_1008, 32'h4c00_0007},
      {EXP_NONE, EXP_ADEM}, {32'h0, 32'h0040_0000}, 2'b00, 32'h0, 32'h0,
      1'b1, 32'h1c00_8000, 32'h1c00_0030, 32'h0048_0000, 32'h0040_0000,
      32'h8765_4000, 32'h0010_0000, 32'h0000_0008},
    '{"same_rd", 2'b11, {5'd9, 5'd9}, {32'hbbbb_0009, 32'haaaa_0009},
      {32'h1c00_0044, 32'h1c00_0040}, {32'h0280_1129, 32'h0280_0929},
      {EXP_NONE, EXP_NONE}, 64'h0, 2'b11, 32'hbbbb_0009, 32'hbbbb_0009,
      1'b0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
    '{"write_r0", 2'b11, {5'd10, 5'd0}, {32'h0a0a_0a0a, 32'hdead_beef},
      {32'h1c00_0054, 32'h1c00_0050}, {32'h0280_140a, 32'h0280_0000},
      {EXP_NONE, EXP_NONE}, 64'h0, 2'b11, 32'h0, 32'h0a0a_0a0a,
      1'b0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0}
};

// ==== tb/tb_wb_subsystem.sv ====
`timescale 1ns/1ps

module tb_wb_subsystem;
    import wb_pkg::*;

    localparam int NUM_LANES  = 2;
    localparam int CLK_PERIOD = 40;

    logic                           clk;
    logic                           reset;
    logic [NUM_LANES-1:0]           eu_valid;
    logic [NUM_LANES*RF_ADDR_W-1:0] eu_rd;
    logic [NUM_LANES*XLEN-1:0]      eu_data;
    logic [NUM_LANES*XLEN-1:0]      eu_pc;
    logic [NUM_LANES*XLEN-1:0]      eu_inst;
    logic [NUM_LANES*EXC_W-1:0]     eu_exception;
    logic [NUM_LANES*XLEN-1:0]      eu_badv;
    logic [RF_ADDR_W-1:0]           rf_raddr0;
    logic [RF_ADDR_W-1:0]           rf_raddr1;
    logic [XLEN-1:0]                rf_rdata0;
    logic [XLEN-1:0]                rf_rdata1;
    logic                           csr_we;
    logic [CSR_ADDR_W-1:0]          csr_waddr;
    logic [XLEN-1:0]                csr_wdata;
    logic [CSR_ADDR_W-1:0]          csr_raddr;
    logic [XLEN-1:0]                csr_rdata;
    logic [NUM_LANES-1:0]           trace_wen;
    logic [NUM_LANES*XLEN-1:0]      trace_pc;
    logic [NUM_LANES*RF_ADDR_W-1:0] trace_rd;
    logic [NUM_LANES*XLEN-1:0]      trace_data;
    logic [NUM_LANES*XLEN-1:0]      trace_inst;
    logic [NUM_LANES*32-1:0]        retire_count;
    logic                           set_pc;
    logic [XLEN-1:0]                redirect_pc;

    logic [31:0] count_exp [NUM_LANES];  // running retire count per lane

    `include "wb_vectors.svh"

    wb_subsystem #(
        .NUM_LANES(NUM_LANES)
    ) u_wb_subsystem (
        .clk         (clk),
        .reset       (reset),
        .eu_valid    (eu_valid),
        .eu_rd       (eu_rd),
        .eu_data     (eu_data),
        .eu_pc       (eu_pc),
        .eu_inst     (eu_inst),
        .eu_exception(eu_exception),
        .eu_badv     (eu_badv),
        .rf_raddr0   (rf_raddr0),
        .rf_rdata0   (rf_rdata0),
        .rf_raddr1   (rf_raddr1),
        .rf_rdata1   (rf_rdata1),
        .csr_we      (csr_we),
        .csr_waddr   (csr_waddr),
        .csr_wdata   (csr_wdata),
        .csr_raddr   (csr_raddr),
        .csr_rdata   (csr_rdata),
        .trace_wen   (trace_wen),
        .trace_pc    (trace_pc),
        .trace_rd    (trace_rd),
        .trace_data  (trace_data),
        .trace_inst  (trace_inst),
        .retire_count(retire_count),
        .set_pc      (set_pc),
        .redirect_pc (redirect_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic write_csr(input logic [CSR_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        csr_we    = 1'b1;
        csr_waddr = addr;
        csr_wdata = data;
        @(posedge clk);
        #2;
        csr_we = 1'b0;
    endtask

    task automatic check_csr(input string name, input logic [CSR_ADDR_W-1:0] addr,
                             input logic [31:0] expected);
        csr_raddr = addr;
        #1;  // read mux settles
        check(name, expected, csr_rdata);
    endtask

    // ------------------------------
    // one table row, cycle N to N+2
    // ------------------------------
    task automatic run_row(input int n);
        vector_t v;
        v = vectors[n];
        @(posedge clk);
        #2;
        eu_valid     = v.valid;
        eu_rd        = v.rd;
        eu_data      = v.data;
        eu_pc        = v.pc;
        eu_inst      = v.inst;
        eu_exception = v.exc;
        eu_badv      = v.badv;
        @(posedge clk);  // N+1, trace and csrs update
        #2;
        eu_valid = '0;
        @(negedge clk);
        for (int i = 0; i < NUM_LANES; i++) begin
            check($sformatf("%s lane%0d trace_wen", v.name, i), v.exp_wen[i], trace_wen[i]);
            if (v.exp_wen[i]) begin
                count_exp[i] = count_exp[i] + 32'd1;
                check($sformatf("%s lane%0d trace_pc", v.name, i), v.pc[i],
                      trace_pc[i*XLEN +: XLEN]);
                check($sformatf("%s lane%0d trace_rd", v.name, i), v.rd[i],
                      trace_rd[i*RF_ADDR_W +: RF_ADDR_W]);
                check($sformatf("%s lane%0d trace_data", v.name, i), v.data[i],
                      trace_data[i*XLEN +: XLEN]);
                check($sformatf("%s lane%0d trace_inst", v.name, i), v.inst[i],
                      trace_inst[i*XLEN +: XLEN]);
            end
            check($sformatf("%s lane%0d retire_count", v.name, i), count_exp[i],
                  retire_count[i*32 +: 32]);
        end
        check({v.name, " set_pc"}, v.exp_take, set_pc);
        if (v.exp_take) begin
            check({v.name, " redirect_pc"}, v.exp_redirect, redirect_pc);
            check_csr({v.name, " era"}, CSR_ERA, v.exp_era);
            check_csr({v.name, " estat"}, CSR_ESTAT, v.exp_estat);
            check_csr({v.name, " badv"}, CSR_BADV, v.exp_badv);
            check_csr({v.name, " tlbehi"}, CSR_TLBEHI, v.exp_tlbehi);
            check_csr({v.name, " pgd"}, CSR_PGD, v.exp_pgd);
            check_csr({v.name, " crmd"}, CSR_CRMD, v.exp_crmd);
        end
        @(posedge clk);  // N+2, regfile written
        #2;
        rf_raddr0 = v.rd[0];
        rf_raddr1 = v.rd[1];
        @(negedge clk);
        check({v.name, " rf lane0 rd"}, v.exp_r0, rf_rdata0);
        check({v.name, " rf lane1 rd"}, v.exp_r1, rf_rdata1);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        eu_valid     = '0;
        eu_rd        = '0;
        eu_data      = '0;
        eu_pc        = '0;
        eu_inst      = '0;
        eu_exception = '0;
        eu_badv      = '0;
        rf_raddr0    = '0;
        rf_raddr1    = '0;
        csr_we       = 1'b0;
        csr_waddr    = '0;
        csr_wdata    = '0;
        csr_raddr    = '0;
        for (int i = 0; i < NUM_LANES; i++)
            count_exp[i] = '0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        write_csr(CSR_CRMD, 32'h0000_0017);  // plv 3, ie, paged
        write_csr(CSR_EENTRY, 32'h1c00_8000);
        write_csr(CSR_TLBRENTRY, 32'h1c00_f000);
        write_csr(CSR_PGDL, 32'h0010_0000);
        write_csr(CSR_PGDH, 32'h0020_0000);
        for (int n = 0; n < NUM_ROWS; n++)
            run_row(n);
        $display("All tests passed!");
        $finish;
    end

    // watchdog
    initial begin
        repeat (NUM_ROWS * 6 + 20) @(posedge clk);
        $display("Timeout: the table loop did not finish within %0d cycles", NUM_ROWS * 6 + 20);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== verilog/wb_subsystem.sv ====
`timescale 1ns/1ps

module wb_subsystem #(
    parameter int NUM_LANES = 2
) (
    input  logic                                   clk,
    input  logic                                   reset,
    // execution unit results
    input  logic [NUM_LANES-1:0]                   eu_valid,
    input  logic [NUM_LANES*wb_pkg::RF_ADDR_W-1:0] eu_rd,
    input  logic [NUM_LANES*wb_pkg::XLEN-1:0]      eu_data,
    input  logic [NUM_LANES*wb_pkg::XLEN-1:0]      eu_pc,
    input  logic [NUM_LANES*wb_pkg::XLEN-1:0]      eu_inst,
    input  logic [NUM_LANES*wb_pkg::EXC_W-1:0]     eu_exception,
    input  logic [NUM_LANES*wb_pkg::XLEN-1:0]      eu_badv,
    // register file read ports
    input  logic [wb_pkg::RF_ADDR_W-1:0]           rf_raddr0,
    output logic [wb_pkg::XLEN-1:0]                rf_rdata0,
    input  logic [wb_pkg::RF_ADDR_W-1:0]           rf_raddr1,
    output logic [wb_pkg::XLEN-1:0]                rf_rdata1,
    // csr port
    input  logic                                   csr_we,
    input  logic [wb_pkg::CSR_ADDR_W-1:0]          csr_waddr,
    input  logic [wb_pkg::XLEN-1:0]                csr_wdata,
    input  logic [wb_pkg::CSR_ADDR_W-1:0]          csr_raddr,
    output logic [wb_pkg::XLEN-1:0]                csr_rdata,
    // debug trace
    output logic [NUM_LANES-1:0]                   trace_wen,
    output logic [NUM_LANES*wb_pkg::XLEN-1:0]      trace_pc,
    output logic [NUM_LANES*wb_pkg::RF_ADDR_W-1:0] trace_rd,
    output logic [NUM_LANES*wb_pkg::XLEN-1:0]      trace_data,
    output logic [NUM_LANES*wb_pkg::XLEN-1:0]      trace_inst,
    output logic [NUM_LANES*32-1:0]                retire_count,
    // redirect
    output logic                                   set_pc,
    output logic [wb_pkg::XLEN-1:0]                redirect_pc
);
    import wb_pkg::*;

    retire_if retire_bus [NUM_LANES] ();
    exc_if    exc_bus ();

    logic [NUM_LANES-1:0]           rf_we;
    logic [NUM_LANES*RF_ADDR_W-1:0] rf_waddr;
    logic [NUM_LANES*XLEN-1:0]      rf_wdata;

    writeback #(
        .NUM_LANES(NUM_LANES)
    ) u_writeback (
        .eu_valid    (eu_valid),
        .eu_rd       (eu_rd),
        .eu_data     (eu_data),
        .eu_pc       (eu_pc),
        .eu_inst     (eu_inst),
        .eu_exception(eu_exception),
        .eu_badv     (eu_badv),
        .retire      (retire_bus),
        .exc         (exc_bus)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_retire
        retire_lane u_retire_lane (
            .clk         (clk),
            .reset       (reset),
            .wb          (retire_bus[i]),
            .rf_we       (rf_we[i]),
            .rf_waddr    (rf_waddr[i*RF_ADDR_W +: RF_ADDR_W]),
            .rf_wdata    (rf_wdata[i*XLEN +: XLEN]),
            .trace_wen   (trace_wen[i]),
            .trace_pc    (trace_pc[i*XLEN +: XLEN]),
            .trace_rd    (trace_rd[i*RF_ADDR_W +: RF_ADDR_W]),
            .trace_data  (trace_data[i*XLEN +: XLEN]),
            .trace_inst  (trace_inst[i*XLEN +: XLEN]),
            .retire_count(retire_count[i*32 +: 32])
        );
    end

    regfile #(
        .NUM_LANES(NUM_LANES)
    ) u_regfile (
        .clk     (clk),
        .reset   (reset),
        .rf_we   (rf_we),
        .rf_waddr(rf_waddr),
        .rf_wdata(rf_wdata),
        .raddr0  (rf_raddr0),
        .raddr1  (rf_raddr1),
        .rdata0  (rf_rdata0),
        .rdata1  (rf_rdata1)
    );

    exception_csr u_exception_csr (
        .clk        (clk),
        .reset      (reset),
        .exc        (exc_bus),
        .csr_we     (csr_we),
        .csr_waddr  (csr_waddr),
        .csr_wdata  (csr_wdata),
        .csr_raddr  (csr_raddr),
        .csr_rdata  (csr_rdata),
        .set_pc     (set_pc),
        .redirect_pc(redirect_pc)
    );

endmodule

// ==== verilog/exception_csr.sv ====
`timescale 1ns/1ps

module exception_csr (
    input  logic                          clk,
    input  logic                          reset,
    exc_if.dst                            exc,
    input  logic                          csr_we,
    input  logic [wb_pkg::CSR_ADDR_W-1:0] csr_waddr,
    input  logic [wb_pkg::XLEN-1:0]       csr_wdata,
    input  logic [wb_pkg::CSR_ADDR_W-1:0] csr_raddr,
    output logic [wb_pkg::XLEN-1:0]       csr_rdata,
    output logic                          set_pc,
    output logic [wb_pkg::XLEN-1:0]       redirect_pc
);
    import wb_pkg::*;

    logic [1:0]      crmd_plv;
    logic            crmd_ie;
    logic            crmd_da;
    logic            crmd_pg;
    logic [1:0]      prmd_pplv;
    logic            prmd_pie;
    exp_code_s       estat_code;
    logic [XLEN-1:0] era;
    logic [XLEN-1:0] badv;
    logic [25:0]     eentry;      // 64-byte aligned
    logic [25:0]     tlbrentry;
    logic [18:0]     tlbehi_vppn;
    logic [19:0]     pgdl;
    logic [19:0]     pgdh;
    logic [19:0]     pgd;
    logic            is_tlbr;

    assign is_tlbr = exc.code.raw == EXP_TLBR;

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv    <= 2'd0;
            crmd_ie     <= 1'b0;
            crmd_da     <= 1'b1;
            crmd_pg     <= 1'b0;
            prmd_pplv   <= 2'd0;
            prmd_pie    <= 1'b0;
            estat_code  <= '0;
            era         <= '0;
            badv        <= '0;
            eentry      <= '0;
            tlbrentry   <= '0;
            tlbehi_vppn <= '0;
            pgdl        <= '0;
            pgdh        <= '0;
            pgd         <= '0;
            set_pc      <= 1'b0;
            redirect_pc <= '0;
        end else begin
            // ------------------------------
            // software port
            // ------------------------------
            if (csr_we) begin
                case (csr_waddr)
                    CSR_CRMD: begin
                        crmd_plv <= csr_wdata[1:0];
                        crmd_ie  <= csr_wdata[2];
                        crmd_da  <= csr_wdata[3];
                        crmd_pg  <= csr_wdata[4];
                    end
                    CSR_PRMD: begin
                        prmd_pplv <= csr_wdata[1:0];
                        prmd_pie  <= csr_wdata[2];
                    end
                    CSR_ERA:       era         <= csr_wdata;
                    CSR_BADV:      badv        <= csr_wdata;
                    CSR_EENTRY:    eentry      <= csr_wdata[31:6];
                    CSR_TLBRENTRY: tlbrentry   <= csr_wdata[31:6];
                    CSR_TLBEHI:    tlbehi_vppn <= csr_wdata[31:13];
                    CSR_PGDL:      pgdl        <= csr_wdata[31:12];
                    CSR_PGDH:      pgdh        <= csr_wdata[31:12];
                    default: ;  // estat and pgd are read-only here
                endcase
            end

            // ------------------------------
            // exception entry, overrides the port
            // ------------------------------
            set_pc <= exc.take;
            if (exc.take) begin
                prmd_pplv   <= crmd_plv;
                prmd_pie    <= crmd_ie;
                crmd_plv    <= 2'd0;
                crmd_ie     <= 1'b0;
                era         <= exc.era_pc;
                estat_code  <= exc.code.split;
                redirect_pc <= is_tlbr ? {tlbrentry, 6'd0} : {eentry, 6'd0};
                if (is_tlbr) begin
                    crmd_da <= 1'b1;  // refill runs untranslated
                    crmd_pg <= 1'b0;
                end
                if (exc.set_badv) begin
                    badv <= exc.vaddr;
                    pgd  <= exc.vaddr[31] ? pgdh : pgdl;
                end
                if (exc.set_vppn)
                    tlbehi_vppn <= exc.vaddr[31:13];
            end
        end
    end

    always_comb begin
        case (csr_raddr)
            CSR_CRMD:      csr_rdata = {27'd0, crmd_pg, crmd_da, crmd_ie, crmd_plv};
            CSR_PRMD:      csr_rdata = {29'd0, prmd_pie, prmd_pplv};
            CSR_ESTAT:     csr_rdata = {9'd0, estat_code.esubcode, estat_code.ecode, 16'd0};
            CSR_ERA:       csr_rdata = era;
            CSR_BADV:      csr_rdata = badv;
            CSR_EENTRY:    csr_rdata = {eentry, 6'd0};
            CSR_TLBRENTRY: csr_rdata = {tlbrentry, 6'd0};
            CSR_TLBEHI:    csr_rdata = {tlbehi_vppn, 13'd0};
            CSR_PGDL:      csr_rdata = {pgdl, 12'd0};
            CSR_PGDH:      csr_rdata = {pgdh, 12'd0};
            CSR_PGD:       csr_rdata = {pgd, 12'd0};
            default:       csr_rdata = '0;
        endcase
    end

    a_set_pc_pulse: assert property (@(posedge clk) disable iff (reset)
        set_pc |=> !set_pc);

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile #(
    parameter int NUM_LANES = 2
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [NUM_LANES-1:0]                   rf_we,
    input  logic [NUM_LANES*wb_pkg::RF_ADDR_W-1:0] rf_waddr,
    input  logic [NUM_LANES*wb_pkg::XLEN-1:0]      rf_wdata,
    input  logic [wb_pkg::RF_ADDR_W-1:0]           raddr0,
    input  logic [wb_pkg::RF_ADDR_W-1:0]           raddr1,
    output logic [wb_pkg::XLEN-1:0]                rdata0,
    output logic [wb_pkg::XLEN-1:0]                rdata1
);
    import wb_pkg::*;

    logic [XLEN-1:0] regs [32];

    // ascending lane order, so the youngest lane lands last
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < 32; r++)
                regs[r] <= '0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (rf_we[i])
                    regs[rf_waddr[i*RF_ADDR_W +: RF_ADDR_W]] <= rf_wdata[i*XLEN +: XLEN];
            end
        end
    end

    assign rdata0 = regs[raddr0];  // combinational read
    assign rdata1 = regs[raddr1];

endmodule

// ==== verilog/retire_lane.sv ====
`timescale 1ns/1ps

module retire_lane (
    input  logic                         clk,
    input  logic                         reset,
    retire_if.dst                        wb,
    output logic                         rf_we,
    output logic [wb_pkg::RF_ADDR_W-1:0] rf_waddr,
    output logic [wb_pkg::XLEN-1:0]      rf_wdata,
    output logic                         trace_wen,
    output logic [wb_pkg::XLEN-1:0]      trace_pc,
    output logic [wb_pkg::RF_ADDR_W-1:0] trace_rd,
    output logic [wb_pkg::XLEN-1:0]      trace_data,
    output logic [wb_pkg::XLEN-1:0]      trace_inst,
    output logic [31:0]                  retire_count
);
    import wb_pkg::*;

    logic                 commit_q;
    logic [RF_ADDR_W-1:0] rd_q;
    logic [XLEN-1:0]      data_q;
    logic [XLEN-1:0]      pc_q;
    logic [XLEN-1:0]      inst_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_q     <= 1'b0;
            retire_count <= '0;
        end else begin
            commit_q <= wb.commit;
            if (wb.commit)
                retire_count <= retire_count + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (wb.commit) begin
            rd_q   <= wb.rd;
            data_q <= wb.data;
            pc_q   <= wb.pc;
            inst_q <= wb.inst;
        end
    end

    // ------------------------------
    // debug trace and rf write
    // ------------------------------
    assign trace_wen  = commit_q;  // r0 writes still show up here
    assign trace_pc   = pc_q;
    assign trace_rd   = rd_q;
    assign trace_data = data_q;
    assign trace_inst = inst_q;

    assign rf_we    = commit_q && rd_q != '0;
    assign rf_waddr = rd_q;
    assign rf_wdata = data_q;

    // a write must come from last cycle's commit, to its rd, never r0
    a_no_r0_write: assert property (@(posedge clk) disable iff (reset)
        rf_we |-> rf_waddr != '0 && $past(wb.commit) && rf_waddr == $past(wb.rd));

endmodule

// ==== verilog/writeback.sv ====
`timescale 1ns/1ps

module writeback #(
    parameter int NUM_LANES = 2
) (
    input  logic [NUM_LANES-1:0]                   eu_valid,
    input  logic [NUM_LANES*wb_pkg::RF_ADDR_W-1:0] eu_rd,
    input  logic [NUM_LANES*wb_pkg::XLEN-1:0]      eu_data,
    input  logic [NUM_LANES*wb_pkg::XLEN-1:0]      eu_pc,
    input  logic [NUM_LANES*wb_pkg::XLEN-1:0]      eu_inst,
    input  logic [NUM_LANES*wb_pkg::EXC_W-1:0]     eu_exception,
    input  logic [NUM_LANES*wb_pkg::XLEN-1:0]      eu_badv,
    retire_if.src                                  retire [NUM_LANES],
    exc_if.src                                     exc
);
    import wb_pkg::*;

    localparam int SEL_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [NUM_LANES-1:0] lane_commit;
    logic                 exc_found;
    logic [SEL_W-1:0]     exc_sel;
    exp_code_u            exc_code;
    logic                 set_badv;
    logic                 set_vppn;

    // ------------------------------
    // commit gating, lane 0 oldest
    // ------------------------------
    always_comb begin
        exc_found = 1'b0;
        exc_sel   = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_commit[i] = eu_valid[i] && !exc_found &&
                             eu_exception[i*EXC_W +: EXC_W] == EXP_NONE;
            if (eu_valid[i] && !exc_found && eu_exception[i*EXC_W +: EXC_W] != EXP_NONE) begin
                exc_found = 1'b1;           // younger lanes are flushed from here on
                exc_sel   = SEL_W'(i);
            end
        end
    end

    assign exc_code.raw = eu_exception[exc_sel*EXC_W +: EXC_W];

    // update class of the taken exception
    always_comb begin
        set_badv = 1'b0;
        set_vppn = 1'b0;
        if (exc_found) begin
            case (exc_code.raw)
                EXP_TLBR, EXP_PIL, EXP_PIS, EXP_PIF, EXP_PME, EXP_PPI: begin
                    set_badv = 1'b1;
                    set_vppn = 1'b1;
                end
                EXP_ADEF, EXP_ADEM, EXP_ALE: set_badv = 1'b1;
                default: ;
            endcase
        end
    end

    assign exc.take     = exc_found;
    assign exc.code     = exc_code;
    assign exc.era_pc   = eu_pc[exc_sel*XLEN +: XLEN];
    assign exc.vaddr    = eu_badv[exc_sel*XLEN +: XLEN];
    assign exc.set_badv = set_badv;
    assign exc.set_vppn = set_vppn;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign retire[i].commit = lane_commit[i];
        assign retire[i].rd     = eu_rd[i*RF_ADDR_W +: RF_ADDR_W];
        assign retire[i].data   = eu_data[i*XLEN +: XLEN];
        assign retire[i].pc     = eu_pc[i*XLEN +: XLEN];
        assign retire[i].inst   = eu_inst[i*XLEN +: XLEN];
    end

    // the lane that feeds the csr block must be a live instruction
    a_take_valid: assert final (!exc.take || eu_valid[exc_sel]);

endmodule

// ==== verilog/exc_if.sv ====
`timescale 1ns/1ps

interface exc_if;
    import wb_pkg::*;

    logic            take;
    exp_code_u       code;
    logic [XLEN-1:0] era_pc;
    logic [XLEN-1:0] vaddr;      // badv of the excepting lane
    logic            set_badv;
    logic            set_vppn;

    modport src (
        output take,
        output code,
        output era_pc,
        output vaddr,
        output set_badv,
        output set_vppn
    );

    modport dst (
        input take,
        input code,
        input era_pc,
        input vaddr,
        input set_badv,
        input set_vppn
    );

endinterface

// ==== verilog/retire_if.sv ====
`timescale 1ns/1ps

interface retire_if;
    import wb_pkg::*;

    logic                 commit;   // one-cycle strobe, no back-pressure
    logic [RF_ADDR_W-1:0] rd;
    logic [XLEN-1:0]      data;
    logic [XLEN-1:0]      pc;
    logic [XLEN-1:0]      inst;

    modport src (
        output commit,
        output rd,
        output data,
        output pc,
        output inst
    );

    modport dst (
        input commit,
        input rd,
        input data,
        input pc,
        input inst
    );

endinterface

// ==== verilog/wb_pkg.sv ====
package wb_pkg;

    localparam int XLEN       = 32;
    localparam int RF_ADDR_W  = 5;
    localparam int EXC_W      = 7;
    localparam int CSR_ADDR_W = 14;

    // ------------------------------
    // exception codes, {esubcode, ecode}
    // ------------------------------
    localparam logic [EXC_W-1:0] EXP_NONE = 7'd0;
    localparam logic [EXC_W-1:0] EXP_PIL  = 7'd1;
    localparam logic [EXC_W-1:0] EXP_PIS  = 7'd2;
    localparam logic [EXC_W-1:0] EXP_PIF  = 7'd3;
    localparam logic [EXC_W-1:0] EXP_PME  = 7'd4;
    localparam logic [EXC_W-1:0] EXP_PPI  = 7'd7;
    localparam logic [EXC_W-1:0] EXP_ADEF = 7'd8;
    localparam logic [EXC_W-1:0] EXP_ALE  = 7'd9;
    localparam logic [EXC_W-1:0] EXP_SYS  = 7'd11;
    localparam logic [EXC_W-1:0] EXP_BRK  = 7'd12;
    localparam logic [EXC_W-1:0] EXP_INE  = 7'd13;
    localparam logic [EXC_W-1:0] EXP_ADEM = 7'd72;  // subcode 1 on top of ecode 8
    localparam logic [EXC_W-1:0] EXP_TLBR = 7'd63;

    typedef struct packed {
        logic       esubcode;
        logic [5:0] ecode;
    } exp_code_s;

    typedef union packed {
        logic [EXC_W-1:0] raw;
        exp_code_s        split;
    } exp_code_u;

    // ------------------------------
    // csr addresses
    // ------------------------------
    localparam logic [CSR_ADDR_W-1:0] CSR_CRMD      = 14'h0;
    localparam logic [CSR_ADDR_W-1:0] CSR_PRMD      = 14'h1;
    localparam logic [CSR_ADDR_W-1:0] CSR_ESTAT     = 14'h5;
    localparam logic [CSR_ADDR_W-1:0] CSR_ERA       = 14'h6;
    localparam logic [CSR_ADDR_W-1:0] CSR_BADV      = 14'h7;
    localparam logic [CSR_ADDR_W-1:0] CSR_EENTRY    = 14'hc;
    localparam logic [CSR_ADDR_W-1:0] CSR_TLBEHI    = 14'h11;
    localparam logic [CSR_ADDR_W-1:0] CSR_PGDL      = 14'h19;
    localparam logic [CSR_ADDR_W-1:0] CSR_PGDH      = 14'h1a;
    localparam logic [CSR_ADDR_W-1:0] CSR_PGD       = 14'h1b;
    localparam logic [CSR_ADDR_W-1:0] CSR_TLBRENTRY = 14'h88;

endpackage
